/* hw/epu_params.svh */
`ifndef EPU_PARAMS_SVH
`define EPU_PARAMS_SVH

// Data and PC widths
`define EPU_DW          32
`define EPU_PCW         30
`define EPU_IMMW        15
`define EPU_PSR_DW      10

// PSR bit positions
`define EPU_PSR_RM      4
`define EPU_PSR_IRE     5
`define EPU_PSR_IMME    6
`define EPU_PSR_DMME    7

// MSR address split, bank field sits right above the offset
`define EPU_BANK_AW     5
`define EPU_BANK_OFF_AW 9

// Bank codes
`define EPU_BANK_PS     5'd0
`define EPU_BANK_IRQC   5'd6
`define EPU_BANK_TSC    5'd7

// One-hot offset bit in the PS bank
`define EPU_MSR_PSR     0
`define EPU_MSR_CPUID   1
`define EPU_MSR_EPSR    2
`define EPU_MSR_EPC     3
`define EPU_MSR_ELSA    4
`define EPU_MSR_COREID  5

// One-hot offset bit in the IRQC and TSC banks
`define EPU_MSR_IMR     0
`define EPU_MSR_IRR     1
`define EPU_MSR_TSR     0
`define EPU_MSR_TCR     1

// Byte addresses of exception handlers
`define EPU_VEC_SYSCALL 32'h0000_000c
`define EPU_VEC_ITM     32'h0000_001c
`define EPU_VEC_IPF     32'h0000_0014
`define EPU_VEC_INSN    32'h0000_0004
`define EPU_VEC_IRQ     32'h0000_0008

`define EPU_CPUID       32'h4e43_0132
`define EPU_COREID      32'h0000_0001

// Core starts in privileged mode, no MMU, no interrupts
`define EPU_PSR_RESET   10'h010

`endif

/* hw/epu_pkg.sv */
`include "epu_params.svh"

package epu_pkg;

   // Decoded operation, at most one bit set
   typedef struct packed {
      logic rmsr;
      logic wmsr;
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
   } epu_opc_t;

   typedef struct packed {
      logic psr;
      logic cpuid;
      logic epsr;
      logic epc;
      logic elsa;
      logic coreid;
      logic imr;
      logic irr;
      logic tsr;
      logic tcr;
   } msr_sel_t;

   // Only registers that software can write
   typedef struct packed {
      logic psr;
      logic epsr;
      logic epc;
      logic elsa;
      logic imr;
      logic tsr;
      logic tcr;
   } msr_we_t;

   typedef struct packed {
      msr_we_t            we;
      logic [`EPU_DW-1:0] dat;
   } wmsr_t;

   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
   } exc_kind_t;

   typedef struct packed {
      logic                 valid;
      logic [`EPU_PCW-1:0]  pc;
      epu_opc_t             opc;
      logic [`EPU_DW-1:0]   operand1;
      logic [`EPU_DW-1:0]   operand2;
      logic [`EPU_IMMW-1:0] imm;
   } issue_t;

   typedef struct packed {
      logic                valid;
      logic [`EPU_PCW-1:0] pc;
      logic [`EPU_DW-1:0]  dout;
      logic                exc;
      exc_kind_t           kind;
      logic [`EPU_PCW-1:0] vec;
      wmsr_t               wmsr;
   } wb_t;

   // Data faults only reach the unit at commit
   typedef struct packed {
      logic [`EPU_PCW-1:0] pc;
      exc_kind_t           kind;
      logic                edtm;
      logic                edpf;
      logic                ealign;
      logic [`EPU_DW-1:0]  lsa;
      wmsr_t               wmsr;
   } commit_t;

   typedef struct packed {
      logic [`EPU_PSR_DW-1:0] psr;
      logic [`EPU_PSR_DW-1:0] epsr;
      logic [`EPU_DW-1:0]     epc;
      logic [`EPU_DW-1:0]     elsa;
      logic [`EPU_DW-1:0]     imr;
      logic [`EPU_DW-1:0]     tsr;
      logic [`EPU_DW-1:0]     tcr;
   } msr_state_t;

endpackage

/* hw/msr_addr_decode.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module msr_addr_decode
   import epu_pkg::*;
(
   input  issue_t   issue,
   output msr_sel_t sel,
   output wmsr_t    wmsr
);

   logic [`EPU_DW-1:0]          addr;
   logic [`EPU_BANK_AW-1:0]     bank;
   logic [`EPU_BANK_OFF_AW-1:0] off;
   logic                        bank_ps;
   logic                        bank_irqc;
   logic                        bank_tsc;
   logic                        wr;

   // Offset must be exactly the one-hot code of the register
   function automatic logic off_is(input logic [`EPU_BANK_OFF_AW-1:0] o,
                                   input int unsigned pos);
      return o == (`EPU_BANK_OFF_AW'(1) << pos);
   endfunction

   assign addr = issue.operand1 | {{(`EPU_DW-`EPU_IMMW){1'b0}}, issue.imm};
   assign bank = addr[`EPU_BANK_OFF_AW +: `EPU_BANK_AW];
   assign off  = addr[`EPU_BANK_OFF_AW-1:0];

   assign bank_ps   = (bank == `EPU_BANK_PS);
   assign bank_irqc = (bank == `EPU_BANK_IRQC);
   assign bank_tsc  = (bank == `EPU_BANK_TSC);

   // Register selects
   assign sel.psr    = bank_ps & off_is(off, `EPU_MSR_PSR);
   assign sel.cpuid  = bank_ps & off_is(off, `EPU_MSR_CPUID);
   assign sel.epsr   = bank_ps & off_is(off, `EPU_MSR_EPSR);
   assign sel.epc    = bank_ps & off_is(off, `EPU_MSR_EPC);
   assign sel.elsa   = bank_ps & off_is(off, `EPU_MSR_ELSA);
   assign sel.coreid = bank_ps & off_is(off, `EPU_MSR_COREID);
   assign sel.imr    = bank_irqc & off_is(off, `EPU_MSR_IMR);
   assign sel.irr    = bank_irqc & off_is(off, `EPU_MSR_IRR);
   assign sel.tsr    = bank_tsc & off_is(off, `EPU_MSR_TSR);
   assign sel.tcr    = bank_tsc & off_is(off, `EPU_MSR_TCR);

   // Write packet, enables only for a valid wmsr
   assign wr = issue.valid & issue.opc.wmsr;

   assign wmsr.we.psr  = wr & sel.psr;
   assign wmsr.we.epsr = wr & sel.epsr;
   assign wmsr.we.epc  = wr & sel.epc;
   assign wmsr.we.elsa = wr & sel.elsa;
   assign wmsr.we.imr  = wr & sel.imr;
   assign wmsr.we.tsr  = wr & sel.tsr;
   assign wmsr.we.tcr  = wr & sel.tcr;
   assign wmsr.dat     = issue.operand2;

endmodule

/* hw/msr_read_mux.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module msr_read_mux
   import epu_pkg::*;
(
   input  msr_sel_t           sel,
   input  msr_state_t         state,
   input  logic [`EPU_DW-1:0] irr,
   output logic [`EPU_DW-1:0] dout
);

   localparam logic [`EPU_DW-1:0] CPUID  = `EPU_CPUID;
   localparam logic [`EPU_DW-1:0] COREID = `EPU_COREID;

   logic [`EPU_DW-1:0] psr_ext;
   logic [`EPU_DW-1:0] epsr_ext;

   assign psr_ext  = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, state.psr};
   assign epsr_ext = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, state.epsr};

   // AND-OR mux, no select means zero
   assign dout = ({`EPU_DW{sel.psr}}    & psr_ext)    |
                 ({`EPU_DW{sel.cpuid}}  & CPUID)      |
                 ({`EPU_DW{sel.epsr}}   & epsr_ext)   |
                 ({`EPU_DW{sel.epc}}    & state.epc)  |
                 ({`EPU_DW{sel.elsa}}   & state.elsa) |
                 ({`EPU_DW{sel.coreid}} & COREID)     |
                 ({`EPU_DW{sel.imr}}    & state.imr)  |
                 ({`EPU_DW{sel.irr}}    & irr)        |
                 ({`EPU_DW{sel.tsr}}    & state.tsr)  |
                 ({`EPU_DW{sel.tcr}}    & state.tcr);

endmodule

/* hw/exc_vector_sel.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module exc_vector_sel
   import epu_pkg::*;
(
   input  epu_opc_t            opc,
   input  logic [`EPU_DW-1:0]  epc,
   output logic                exc,
   output exc_kind_t           kind,
   output logic [`EPU_PCW-1:0] vec
);

   localparam logic [`EPU_DW-1:0] VEC_SYSCALL = `EPU_VEC_SYSCALL;
   localparam logic [`EPU_DW-1:0] VEC_ITM     = `EPU_VEC_ITM;
   localparam logic [`EPU_DW-1:0] VEC_IPF     = `EPU_VEC_IPF;
   localparam logic [`EPU_DW-1:0] VEC_INSN    = `EPU_VEC_INSN;
   localparam logic [`EPU_DW-1:0] VEC_IRQ     = `EPU_VEC_IRQ;

   assign kind.eret     = opc.eret;
   assign kind.esyscall = opc.esyscall;
   assign kind.einsn    = opc.einsn;
   assign kind.eipf     = opc.eipf;
   assign kind.eitm     = opc.eitm;
   assign kind.eirq     = opc.eirq;

   assign exc = |kind;

   // Word address of the target, eret returns to EPC
   assign vec = ({`EPU_PCW{kind.eret}}     & epc[`EPU_DW-1:2])         |
                ({`EPU_PCW{kind.esyscall}} & VEC_SYSCALL[`EPU_DW-1:2]) |
                ({`EPU_PCW{kind.eitm}}     & VEC_ITM[`EPU_DW-1:2])     |
                ({`EPU_PCW{kind.eipf}}     & VEC_IPF[`EPU_DW-1:2])     |
                ({`EPU_PCW{kind.einsn}}    & VEC_INSN[`EPU_DW-1:2])    |
                ({`EPU_PCW{kind.eirq}}     & VEC_IRQ[`EPU_DW-1:2]);

endmodule

/* hw/msr_commit.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module msr_commit
   import epu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  commit_t                commit,
   input  msr_state_t             state,
   output logic [`EPU_PSR_DW-1:0] psr_nxt,
   output logic                   psr_we,
   output logic [`EPU_PSR_DW-1:0] epsr_nxt,
   output logic                   epsr_we,
   output logic [`EPU_DW-1:0]     epc_nxt,
   output logic                   epc_we,
   output logic [`EPU_DW-1:0]     elsa_nxt,
   output logic                   elsa_we,
   output logic                   exc_ent
);

   logic                   data_fault;
   logic                   exc_commit;
   logic                   exc_ent_q;
   logic                   save_psr;
   logic [`EPU_PSR_DW-1:0] psr_src;
   logic [`EPU_PCW-1:0]    linkaddr;
   logic                   elsa_is_pc;
   logic                   elsa_set;

   assign data_fault = commit.edtm | commit.edpf | commit.ealign;
   assign exc_commit = (|commit.kind) | data_fault;

   // Entry is any exception except the return
   assign exc_ent = exc_commit & ~commit.kind.eret;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exc_ent_q <= 1'b0;
      end else begin
         exc_ent_q <= exc_ent;
      end
   end

   // Only the first cycle of a run saves PSR
   assign save_psr = exc_ent & ~exc_ent_q;

   // PSR mode bits come from wmsr data or back from EPSR
   assign psr_we  = commit.wmsr.we.psr | commit.kind.eret;
   assign psr_src = commit.wmsr.we.psr ? commit.wmsr.dat[`EPU_PSR_DW-1:0] : state.epsr;

   always_comb begin
      psr_nxt               = state.psr;
      psr_nxt[`EPU_PSR_RM]   = psr_src[`EPU_PSR_RM];
      psr_nxt[`EPU_PSR_IRE]  = psr_src[`EPU_PSR_IRE];
      psr_nxt[`EPU_PSR_IMME] = psr_src[`EPU_PSR_IMME];
      psr_nxt[`EPU_PSR_DMME] = psr_src[`EPU_PSR_DMME];
   end

   assign epsr_we  = commit.wmsr.we.epsr | save_psr;
   assign epsr_nxt = commit.wmsr.we.epsr ? commit.wmsr.dat[`EPU_PSR_DW-1:0] : state.psr;

   // Syscall resumes after itself, other exceptions retry the op
   assign linkaddr = commit.pc + `EPU_PCW'(1);
   assign epc_we   = exc_ent | commit.wmsr.we.epc;

   always_comb begin
      if (commit.wmsr.we.epc) begin
         epc_nxt = commit.wmsr.dat;
      end else if (commit.kind.esyscall) begin
         epc_nxt = {linkaddr, 2'b00};
      end else begin
         epc_nxt = {commit.pc, 2'b00};
      end
   end

   // Instruction-side faults report the PC as the address
   assign elsa_is_pc = commit.kind.eitm | commit.kind.eipf | commit.kind.einsn;
   assign elsa_set   = elsa_is_pc | data_fault;
   assign elsa_we    = elsa_set | commit.wmsr.we.elsa;

   always_comb begin
      if (elsa_is_pc) begin
         elsa_nxt = {commit.pc, 2'b00};
      end else if (data_fault) begin
         elsa_nxt = commit.lsa;
      end else begin
         elsa_nxt = commit.wmsr.dat;
      end
   end

endmodule

/* hw/msr_file.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module msr_file
   import epu_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [`EPU_PSR_DW-1:0] psr_nxt,
   input  logic                   psr_we,
   input  logic [`EPU_PSR_DW-1:0] epsr_nxt,
   input  logic                   epsr_we,
   input  logic [`EPU_DW-1:0]     epc_nxt,
   input  logic                   epc_we,
   input  logic [`EPU_DW-1:0]     elsa_nxt,
   input  logic                   elsa_we,
   input  wmsr_t                  wmsr,
   output msr_state_t             state
);

   // Exception registers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state.psr  <= `EPU_PSR_RESET;
         state.epsr <= '0;
         state.epc  <= '0;
         state.elsa <= '0;
      end else begin
         if (psr_we) begin
            state.psr <= psr_nxt;
         end
         if (epsr_we) begin
            state.epsr <= epsr_nxt;
         end
         if (epc_we) begin
            state.epc <= epc_nxt;
         end
         if (elsa_we) begin
            state.elsa <= elsa_nxt;
         end
      end
   end

   // Interrupt mask and timestamp control
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state.imr <= '0;
         state.tcr <= '0;
      end else begin
         if (wmsr.we.imr) begin
            state.imr <= wmsr.dat;
         end
         if (wmsr.we.tcr) begin
            state.tcr <= wmsr.dat;
         end
      end
   end

   // Free-running timestamp, a write takes priority over counting
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state.tsr <= '0;
      end else if (wmsr.we.tsr) begin
         state.tsr <= wmsr.dat;
      end else if (state.tcr[0]) begin
         state.tsr <= state.tsr + 1'b1;
      end
   end

endmodule

/* hw/wb_pipe_reg.sv */
`timescale 1ns/100ps

module wb_pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  payload_t d,
   output payload_t q
);

   // Cleared payload carries no valid, exc or write enables
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q <= '0;
      end else begin
         q <= d;
      end
   end

endmodule

/* hw/epu_top.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module epu_top
   import epu_pkg::*;
(
   input  logic               clk,
   input  logic               arst_n,
   input  issue_t             issue,
   input  commit_t            commit,
   input  logic [`EPU_DW-1:0] irr,
   output wb_t                wb,
   output logic               exc_ent
);

   msr_sel_t               sel;
   wmsr_t                  wmsr_iss;
   logic [`EPU_DW-1:0]     dout;
   logic                   exc;
   exc_kind_t              kind;
   logic [`EPU_PCW-1:0]    vec;
   wb_t                    wb_d;
   logic [`EPU_PSR_DW-1:0] psr_wb;
   msr_state_t             state;
   msr_state_t             commit_state;
   logic [`EPU_PSR_DW-1:0] psr_nxt;
   logic                   psr_we;
   logic [`EPU_PSR_DW-1:0] epsr_nxt;
   logic                   epsr_we;
   logic [`EPU_DW-1:0]     epc_nxt;
   logic                   epc_we;
   logic [`EPU_DW-1:0]     elsa_nxt;
   logic                   elsa_we;

   // Issue side
   msr_addr_decode u_decode (.issue(issue), .sel(sel), .wmsr(wmsr_iss));

   msr_read_mux u_read_mux (.sel(sel), .state(state), .irr(irr), .dout(dout));

   exc_vector_sel u_vec_sel (
      .opc  (issue.opc),
      .epc  (state.epc),
      .exc  (exc),
      .kind (kind),
      .vec  (vec)
   );

   assign wb_d = '{valid: issue.valid, pc: issue.pc, dout: dout, exc: exc,
                   kind: kind, vec: vec, wmsr: wmsr_iss};

   wb_pipe_reg #(.payload_t(wb_t)) u_wb_reg (.clk(clk), .arst_n(arst_n), .d(wb_d), .q(wb));

   // PSR seen by the op now in writeback, the source of the EPSR save
   wb_pipe_reg #(.payload_t(logic [`EPU_PSR_DW-1:0])) u_psr_reg (
      .clk    (clk),
      .arst_n (arst_n),
      .d      (state.psr),
      .q      (psr_wb)
   );

   always_comb begin
      commit_state     = state;
      commit_state.psr = psr_wb;
   end

   // Commit side
   msr_commit u_commit (
      .clk      (clk),
      .arst_n   (arst_n),
      .commit   (commit),
      .state    (commit_state),
      .psr_nxt  (psr_nxt),
      .psr_we   (psr_we),
      .epsr_nxt (epsr_nxt),
      .epsr_we  (epsr_we),
      .epc_nxt  (epc_nxt),
      .epc_we   (epc_we),
      .elsa_nxt (elsa_nxt),
      .elsa_we  (elsa_we),
      .exc_ent  (exc_ent)
   );

   msr_file u_file (
      .clk      (clk),
      .arst_n   (arst_n),
      .psr_nxt  (psr_nxt),
      .psr_we   (psr_we),
      .epsr_nxt (epsr_nxt),
      .epsr_we  (epsr_we),
      .epc_nxt  (epc_nxt),
      .epc_we   (epc_we),
      .elsa_nxt (elsa_nxt),
      .elsa_we  (elsa_we),
      .wmsr     (commit.wmsr),
      .state    (state)
   );

endmodule

/* tb/epu_tb.sv */
`timescale 1ns/100ps
`include "epu_params.svh"

module epu_tb
   import epu_pkg::*;
();

   localparam int unsigned SEED = 32'h55ce_8f69;
   // Whole run is a few hundred cycles, so this leaves a wide margin
   localparam int MAX_CYCLES = 2000;

   // One-hot opcodes, bit order as in epu_opc_t
   localparam epu_opc_t OPC_RMSR     = 8'h80;
   localparam epu_opc_t OPC_WMSR     = 8'h40;
   localparam epu_opc_t OPC_ERET     = 8'h20;
   localparam epu_opc_t OPC_ESYSCALL = 8'h10;
   localparam epu_opc_t OPC_EINSN    = 8'h08;
   localparam epu_opc_t OPC_EIPF     = 8'h04;
   localparam epu_opc_t OPC_EITM     = 8'h02;
   localparam epu_opc_t OPC_EIRQ     = 8'h01;

   // Expected exception kind, bit order as in exc_kind_t
   localparam exc_kind_t KIND_ERET     = 6'h20;
   localparam exc_kind_t KIND_ESYSCALL = 6'h10;
   localparam exc_kind_t KIND_EINSN    = 6'h08;
   localparam exc_kind_t KIND_EIPF     = 6'h04;
   localparam exc_kind_t KIND_EITM     = 6'h02;
   localparam exc_kind_t KIND_EIRQ     = 6'h01;

   // PSR bits restored by eret
   localparam logic [`EPU_DW-1:0] MODE_MASK = (32'd1 << `EPU_PSR_RM) | (32'd1 << `EPU_PSR_IRE) |
                                             (32'd1 << `EPU_PSR_IMME) | (32'd1 << `EPU_PSR_DMME);

   logic               clk;
   logic               arst_n;
   issue_t             issue;
   commit_t            commit;
   logic [`EPU_DW-1:0] irr;
   wb_t                wb;
   logic               exc_ent;

   wb_t  wb_s;
   logic ent_s;
   int   errors = 0;
   int   checks = 0;
   int   cycles = 0;

   epu_top DUT (
      .clk     (clk),
      .arst_n  (arst_n),
      .issue   (issue),
      .commit  (commit),
      .irr     (irr),
      .wb      (wb),
      .exc_ent (exc_ent)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_data(input string name, input logic [`EPU_DW-1:0] exp,
                             input logic [`EPU_DW-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error in %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_vec(input string name, input logic [`EPU_PCW-1:0] exp,
                            input logic [`EPU_PCW-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error in %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error in %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_kind(input string name, input exc_kind_t exp, input exc_kind_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error in %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_wmsr(input string name, input wmsr_t exp, input wmsr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error in %s: expected we=%b dat=%h, actual we=%b dat=%h",
                  name, exp.we, exp.dat, act.we, act.dat);
      end
   endtask

   // Bank above the offset, one-hot offset bit
   function automatic logic [`EPU_DW-1:0] msr_addr(input logic [`EPU_BANK_AW-1:0] bank,
                                                   input int pos);
      return (32'(bank) << `EPU_BANK_OFF_AW) | (32'd1 << pos);
   endfunction

   task automatic apply_commit(input commit_t c);
      @(posedge clk);
      commit <= c;
      @(negedge clk);
      ent_s = exc_ent;
      @(posedge clk);
      commit <= '0;
   endtask

   // One op through issue, wb captured one cycle later
   task automatic do_issue(input string name, input epu_opc_t opc,
                           input logic [`EPU_DW-1:0] addr, input logic [`EPU_DW-1:0] wdat,
                           input logic loop_back);
      issue_t              op;
      commit_t             c;
      logic [`EPU_PCW-1:0] pc;
      pc = `EPU_PCW'($urandom);
      op = '0;
      op.valid    = 1'b1;
      op.pc       = pc;
      op.opc      = opc;
      // Address split over operand1 and the immediate
      op.operand1 = addr & 32'hffff_ff00;
      op.imm      = addr[`EPU_IMMW-1:0] & 15'h00ff;
      op.operand2 = wdat;
      @(posedge clk);
      issue <= op;
      @(posedge clk);
      issue <= '0;
      @(negedge clk);
      wb_s = wb;
      check_bit({name, " valid"}, 1'b1, wb_s.valid);
      check_vec({name, " pc"}, pc, wb_s.pc);
      if (loop_back) begin
         c = '0;
         c.wmsr = wb_s.wmsr;
         apply_commit(c);
      end
   endtask

   task automatic read_msr(input string name, input logic [`EPU_BANK_AW-1:0] bank,
                           input int pos, output logic [`EPU_DW-1:0] data);
      do_issue(name, OPC_RMSR, msr_addr(bank, pos), '0, 1'b0);
      data = wb_s.dout;
   endtask

   task automatic check_read(input string name, input logic [`EPU_BANK_AW-1:0] bank,
                             input int pos, input logic [`EPU_DW-1:0] exp);
      do_issue(name, OPC_RMSR, msr_addr(bank, pos), '0, 1'b0);
      check_data(name, exp, wb_s.dout);
   endtask

   task automatic write_msr(input string name, input logic [`EPU_BANK_AW-1:0] bank,
                            input int pos, input logic [`EPU_DW-1:0] data);
      do_issue(name, OPC_WMSR, msr_addr(bank, pos), data, 1'b1);
   endtask

   task automatic check_vector(input string name, input epu_opc_t opc, input exc_kind_t kind,
                               input logic [`EPU_DW-1:0] byte_addr);
      do_issue(name, opc, '0, '0, 1'b0);
      check_bit({name, " exc"}, 1'b1, wb_s.exc);
      check_kind({name, " kind"}, kind, wb_s.kind);
      check_vec(name, byte_addr[`EPU_DW-1:2], wb_s.vec);
   endtask

   // Write packet check, commit, then readback
   task automatic roundtrip(input string name, input logic [`EPU_BANK_AW-1:0] bank,
                            input int pos, input msr_we_t we);
      wmsr_t exp;
      exp.we  = we;
      exp.dat = $urandom;
      write_msr(name, bank, pos, exp.dat);
      check_wmsr({name, " packet"}, exp, wb_s.wmsr);
      check_read({name, " readback"}, bank, pos, exp.dat);
   endtask

   task automatic test_reset();
      wmsr_t none;
      none = '0;
      @(negedge clk);
      check_bit("reset wb valid", 1'b0, wb.valid);
      check_bit("reset wb exc", 1'b0, wb.exc);
      check_wmsr("reset wb wmsr", none, wb.wmsr);
      check_bit("reset exc_ent", 1'b0, exc_ent);
      check_read("reset psr", `EPU_BANK_PS, `EPU_MSR_PSR, 32'(`EPU_PSR_RESET));
      check_wmsr("reset read no write", none, wb_s.wmsr);
      check_bit("reset read no exc", 1'b0, wb_s.exc);
      check_kind("reset read no kind", '0, wb_s.kind);
      check_read("reset cpuid", `EPU_BANK_PS, `EPU_MSR_CPUID, `EPU_CPUID);
      check_read("reset coreid", `EPU_BANK_PS, `EPU_MSR_COREID, `EPU_COREID);
      check_read("reset epc", `EPU_BANK_PS, `EPU_MSR_EPC, 32'd0);
      check_read("reset elsa", `EPU_BANK_PS, `EPU_MSR_ELSA, 32'd0);
      check_read("reset unmapped", 5'd3, 0, 32'd0);
   endtask

   task automatic test_write_roundtrip();
      msr_we_t            we;
      logic [`EPU_DW-1:0] d;
      we = '0;
      we.epc = 1'b1;
      roundtrip("write epc", `EPU_BANK_PS, `EPU_MSR_EPC, we);
      we = '0;
      we.elsa = 1'b1;
      roundtrip("write elsa", `EPU_BANK_PS, `EPU_MSR_ELSA, we);
      we = '0;
      we.imr = 1'b1;
      roundtrip("write imr", `EPU_BANK_IRQC, `EPU_MSR_IMR, we);
      we = '0;
      we.tcr = 1'b1;
      roundtrip("write tcr", `EPU_BANK_TSC, `EPU_MSR_TCR, we);
      d = $urandom;
      @(posedge clk);
      irr <= d;
      check_read("read irr", `EPU_BANK_IRQC, `EPU_MSR_IRR, d);
   endtask

   task automatic test_syscall();
      logic [`EPU_DW-1:0]  psr_prior;
      logic [`EPU_PCW-1:0] pc;
      commit_t             c;
      // PSR untouched since reset
      psr_prior = 32'(`EPU_PSR_RESET);
      check_read("syscall psr before", `EPU_BANK_PS, `EPU_MSR_PSR, psr_prior);
      check_vector("syscall vector", OPC_ESYSCALL, KIND_ESYSCALL, `EPU_VEC_SYSCALL);
      pc = `EPU_PCW'($urandom);
      c = '0;
      c.pc = pc;
      c.kind.esyscall = 1'b1;
      apply_commit(c);
      check_bit("syscall exc_ent", 1'b1, ent_s);
      check_read("syscall epc", `EPU_BANK_PS, `EPU_MSR_EPC, (32'(pc) + 32'd1) * 32'd4);
      check_read("syscall epsr", `EPU_BANK_PS, `EPU_MSR_EPSR, psr_prior);
   endtask

   task automatic test_eret();
      logic [`EPU_DW-1:0] epsr_val;
      logic [`EPU_DW-1:0] psr_prior;
      logic [`EPU_DW-1:0] epc_val;
      commit_t            c;
      // Bit 0 set too, it must not reach PSR
      epsr_val  = 32'h0000_00e1;
      epc_val   = $urandom;
      psr_prior = 32'(`EPU_PSR_RESET);
      write_msr("eret epsr write", `EPU_BANK_PS, `EPU_MSR_EPSR, epsr_val);
      write_msr("eret epc write", `EPU_BANK_PS, `EPU_MSR_EPC, epc_val);
      check_read("eret psr before", `EPU_BANK_PS, `EPU_MSR_PSR, psr_prior);
      check_vector("eret vector", OPC_ERET, KIND_ERET, epc_val);
      c = '0;
      c.pc = `EPU_PCW'($urandom);
      c.kind.eret = 1'b1;
      apply_commit(c);
      check_bit("eret exc_ent", 1'b0, ent_s);
      check_read("eret psr", `EPU_BANK_PS, `EPU_MSR_PSR,
                 (psr_prior & ~MODE_MASK) | (epsr_val & MODE_MASK));
   endtask

   task automatic test_faults();
      logic [`EPU_PCW-1:0] pc;
      logic [`EPU_DW-1:0]  lsa;
      commit_t             c;
      check_vector("insn vector", OPC_EINSN, KIND_EINSN, `EPU_VEC_INSN);
      check_vector("ipf vector", OPC_EIPF, KIND_EIPF, `EPU_VEC_IPF);
      check_vector("itm vector", OPC_EITM, KIND_EITM, `EPU_VEC_ITM);
      check_vector("irq vector", OPC_EIRQ, KIND_EIRQ, `EPU_VEC_IRQ);
      pc = `EPU_PCW'($urandom);
      c = '0;
      c.pc = pc;
      c.kind.einsn = 1'b1;
      apply_commit(c);
      check_bit("insn fault exc_ent", 1'b1, ent_s);
      check_read("insn fault elsa", `EPU_BANK_PS, `EPU_MSR_ELSA, 32'(pc) * 32'd4);
      check_read("insn fault epc", `EPU_BANK_PS, `EPU_MSR_EPC, 32'(pc) * 32'd4);
      pc  = `EPU_PCW'($urandom);
      lsa = $urandom;
      c = '0;
      c.pc   = pc;
      c.edpf = 1'b1;
      c.lsa  = lsa;
      apply_commit(c);
      check_bit("data fault exc_ent", 1'b1, ent_s);
      check_read("data fault elsa", `EPU_BANK_PS, `EPU_MSR_ELSA, lsa);
      check_read("data fault epc", `EPU_BANK_PS, `EPU_MSR_EPC, 32'(pc) * 32'd4);
   endtask

   task automatic test_timestamp();
      logic [`EPU_DW-1:0] t0;
      logic [`EPU_DW-1:0] t1;
      logic [`EPU_DW-1:0] t2;
      write_msr("ts tcr off", `EPU_BANK_TSC, `EPU_MSR_TCR, 32'd0);
      // Top bit clear so counting cannot wrap
      t0 = $urandom & 32'h7fff_ffff;
      write_msr("ts tsr write", `EPU_BANK_TSC, `EPU_MSR_TSR, t0);
      check_read("ts tsr written", `EPU_BANK_TSC, `EPU_MSR_TSR, t0);
      repeat (6) @(posedge clk);
      check_read("ts tsr held", `EPU_BANK_TSC, `EPU_MSR_TSR, t0);
      write_msr("ts tcr on", `EPU_BANK_TSC, `EPU_MSR_TCR, 32'd1);
      read_msr("ts first read", `EPU_BANK_TSC, `EPU_MSR_TSR, t1);
      repeat (4) @(posedge clk);
      read_msr("ts second read", `EPU_BANK_TSC, `EPU_MSR_TSR, t2);
      check_bit("ts tsr counts", 1'b1, t2 > t1);
   endtask

   initial begin
      void'($urandom(SEED));
      arst_n = 1'b0;
      issue  = '0;
      commit = '0;
      irr    = '0;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      test_reset();
      test_write_roundtrip();
      test_syscall();
      test_eret();
      test_faults();
      test_timestamp();
      @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+hw
hw/epu_pkg.sv
hw/msr_addr_decode.sv
hw/msr_read_mux.sv
hw/exc_vector_sel.sv
hw/msr_commit.sv
hw/msr_file.sv
hw/wb_pipe_reg.sv
hw/epu_top.sv
tb/epu_tb.sv

/* Bender.yml */
package:
  name: epu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/epu_pkg.sv
      - hw/msr_addr_decode.sv
      - hw/msr_read_mux.sv
      - hw/exc_vector_sel.sv
      - hw/msr_commit.sv
      - hw/msr_file.sv
      - hw/wb_pipe_reg.sv
      - hw/epu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/epu_tb.sv
